/* design/fir_config_regs.sv */
`timescale 1ns/10ps
`include "fir_settings.svh"

module fir_config_regs
    import fir_pkg::*;
(
    input  logic       axis_clk,
    input  logic       axis_rst_n,
    input  logic       awvalid,
    input  logic       wvalid,
    input  logic       arvalid,
    input  logic       rready,
    input  addr_t      awaddr,
    input  addr_t      araddr,
    input  data_word_t wdata,
    output logic       awready,
    output logic       wready,
    output logic       arready,
    output logic       rvalid,
    output data_word_t rdata,
    input  idx_t       tap_idx,
    output data_word_t tap_coef,
    input  logic       run_done,
    output logic       start,
    output fir_cfg_t   cfg
);

    logic                ap_idle;
    logic                ap_done;
    logic                ap_start;
    data_word_t          data_len;
    logic [`FIR_IDX_W:0] tap_num;
    data_word_t          coef [`FIR_MAX_TAPS];

    ctrl_word_u          wr_word;
    ctrl_word_u          rd_next;
    ctrl_word_u          rd_word;
    logic                rd_is_ctrl;
    logic                wr_fire;
    logic                rd_fire;

    function automatic logic is_tap_addr(addr_t a);
        return (a >= `FIR_TAP_BASE) && (a < `FIR_TAP_BASE + 4 * `FIR_MAX_TAPS);
    endfunction

    function automatic idx_t tap_of(addr_t a);
        return a[`FIR_IDX_W+1:2];
    endfunction

    //////////////////////////////////////////////////
    // axi-lite handshakes
    //////////////////////////////////////////////////

    assign wr_fire = awready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready    <= 1'b0;
            wready     <= 1'b0;
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rd_is_ctrl <= 1'b0;
        end else begin
            // address and data accepted together
            awready <= awvalid && wvalid && !awready;
            wready  <= awvalid && wvalid && !awready;
            arready <= arvalid && !arready && !rvalid;
            if (rd_fire) begin
                rvalid     <= 1'b1;
                rd_is_ctrl <= (araddr == `FIR_REG_AP_CTRL);
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // read word held stable while rvalid waits
    always_ff @(posedge axis_clk) begin
        if (rd_fire) begin
            rd_word <= rd_next;
        end
    end

    assign rdata = rd_word.raw;

    //////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////

    assign wr_word.raw = wdata;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ap_idle  <= 1'b1;
            ap_done  <= 1'b0;
            ap_start <= 1'b0;
            data_len <= '0;
            tap_num  <= '0;
        end else begin
            ap_start <= 1'b0;
            if (ap_start) begin
                ap_idle <= 1'b0;
            end
            if (wr_fire && ap_idle && !ap_start) begin
                if (awaddr == `FIR_REG_AP_CTRL && wr_word.ctrl.start) begin
                    ap_start <= 1'b1;
                end
                if (awaddr == `FIR_REG_LENGTH) begin
                    data_len <= wdata;
                end
                if (awaddr == `FIR_REG_TAPS) begin
                    tap_num <= wdata[`FIR_IDX_W:0];
                end
            end
            if (run_done) begin
                ap_done <= 1'b1;
            end
            // host saw done, back to idle
            if (rvalid && rready && rd_is_ctrl && rd_word.ctrl.done) begin
                ap_done <= 1'b0;
                ap_idle <= 1'b1;
            end
        end
    end

    // coefficient storage
    always_ff @(posedge axis_clk) begin
        if (wr_fire && ap_idle && is_tap_addr(awaddr)) begin
            coef[tap_of(awaddr)] <= wdata;
        end
    end

    always_comb begin
        rd_next.raw = '0;
        case (araddr)
            `FIR_REG_AP_CTRL: begin
                rd_next.ctrl.idle  = ap_idle;
                rd_next.ctrl.done  = ap_done;
                rd_next.ctrl.start = ap_start;
            end
            `FIR_REG_LENGTH: rd_next.raw = data_len;
            `FIR_REG_TAPS:   rd_next.raw = data_word_t'(tap_num);
            default: begin
                if (is_tap_addr(araddr)) begin
                    rd_next.raw = coef[tap_of(araddr)];
                end
            end
        endcase
    end

    // engine side
    assign tap_coef = coef[tap_idx];
    assign start    = ap_start;
    assign cfg      = '{data_len: data_len, tap_num: tap_num};

endmodule

/* design/fir_mac_engine.sv */
`timescale 1ns/10ps

module fir_mac_engine
    import fir_pkg::*;
(
    input  logic       axis_clk,
    input  logic       axis_rst_n,
    input  logic       start,
    output logic       run_done,
    input  fir_cfg_t   cfg,
    input  logic       ss_tvalid,
    input  data_word_t ss_tdata,
    output logic       ss_tready,
    input  logic       sm_tready,
    output logic       sm_tvalid,
    output logic       sm_tlast,
    output data_word_t sm_tdata,
    output sample_wr_t wr,
    output idx_t       offset,
    output idx_t       tap_idx,
    input  data_word_t sample,
    input  data_word_t tap_coef
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_COMP,
        S_HOLD
    } state_t;

    state_t     state;
    data_word_t out_cnt;
    idx_t       idx;
    logic       issue_en;
    logic       idx_last;
    logic       wr_we;
    data_word_t wr_data;
    logic       v_hx;
    logic       last_hx;
    logic       v_m;
    logic       last_m;
    logic       fin;
    logic       ss_hs;
    data_word_t h_q;
    data_word_t x_q;
    data_word_t m_q;
    data_word_t acc;

    assign ss_tready = (state == S_WAIT);
    assign ss_hs     = ss_tvalid && ss_tready;
    assign idx_last  = ({1'b0, idx} == cfg.tap_num - 1'b1);
    assign fin       = v_m && last_m;
    assign run_done  = sm_tvalid && sm_tready && sm_tlast;

    //////////////////////////////////////////////////
    // sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state     <= S_IDLE;
            out_cnt   <= '0;
            idx       <= '0;
            issue_en  <= 1'b0;
            wr_we     <= 1'b0;
            v_hx      <= 1'b0;
            last_hx   <= 1'b0;
            v_m       <= 1'b0;
            last_m    <= 1'b0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else begin
            // sample lands in history one cycle after intake
            wr_we   <= ss_hs;
            v_hx    <= issue_en;
            last_hx <= issue_en && idx_last;
            v_m     <= v_hx;
            last_m  <= last_hx;

            if (ss_hs) begin
                idx <= '0;
            end else if (wr_we) begin
                issue_en <= 1'b1;
            end else if (issue_en) begin
                if (idx_last) begin
                    issue_en <= 1'b0;
                end else begin
                    idx <= idx + 1'b1;
                end
            end

            case (state)
                S_IDLE: begin
                    if (start) begin
                        state   <= S_WAIT;
                        out_cnt <= '0;
                    end
                end
                S_WAIT: begin
                    if (ss_hs) begin
                        state <= S_COMP;
                    end
                end
                S_COMP: begin
                    if (fin) begin
                        state     <= S_HOLD;
                        sm_tvalid <= 1'b1;
                        sm_tlast  <= (out_cnt == cfg.data_len - 1'b1);
                    end
                end
                default: begin
                    // hold result until the sink takes it
                    if (sm_tready) begin
                        sm_tvalid <= 1'b0;
                        sm_tlast  <= 1'b0;
                        out_cnt   <= out_cnt + 1'b1;
                        state     <= sm_tlast ? S_IDLE : S_WAIT;
                    end
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // multiply-accumulate datapath
    //////////////////////////////////////////////////

    always_ff @(posedge axis_clk) begin
        if (ss_hs) begin
            wr_data <= ss_tdata;
        end
        if (issue_en) begin
            h_q <= tap_coef;
            x_q <= sample;
        end
        // low 32 bits of the product only
        m_q <= h_q * x_q;
        if (ss_hs) begin
            acc <= '0;
        end else if (v_m) begin
            acc <= acc + m_q;
        end
    end

    assign wr       = '{we: wr_we, data: wr_data};
    assign offset   = idx;
    assign tap_idx  = idx;
    assign sm_tdata = acc;

endmodule

/* design/fir_pkg.sv */
`include "fir_settings.svh"

package fir_pkg;

    // basic words
    typedef logic [`FIR_DATA_W-1:0] data_word_t;
    typedef logic [`FIR_ADDR_W-1:0] addr_t;
    typedef logic [`FIR_IDX_W-1:0]  idx_t;

    // ap_ctrl layout, status bits at the bottom
    typedef struct packed {
        logic [`FIR_DATA_W-4:0] pad;
        logic                   idle;
        logic                   done;
        logic                   start;
    } ap_ctrl_t;

    // same word seen raw or as ap_ctrl
    typedef union packed {
        data_word_t raw;
        ap_ctrl_t   ctrl;
    } ctrl_word_u;

    // run configuration
    typedef struct packed {
        data_word_t           data_len;
        logic [`FIR_IDX_W:0]  tap_num;
    } fir_cfg_t;

    // one sample write into the history
    typedef struct packed {
        logic       we;
        data_word_t data;
    } sample_wr_t;

endpackage

/* design/fir_sample_buffer.sv */
`timescale 1ns/10ps
`include "fir_settings.svh"

module fir_sample_buffer
    import fir_pkg::*;
(
    input  logic       axis_clk,
    input  logic       axis_rst_n,
    input  logic       start,
    input  sample_wr_t wr,
    input  idx_t       offset,
    output data_word_t sample
);

    data_word_t          mem [`FIR_MAX_TAPS];
    idx_t                wr_ptr;
    idx_t                rd_ptr;
    logic [`FIR_IDX_W:0] valid_cnt;
    logic                in_range;

    //////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ptr    <= '0;
            valid_cnt <= '0;
        end else begin
            if (wr.we) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // new run forgets earlier history
            if (start) begin
                valid_cnt <= '0;
            end else if (wr.we && valid_cnt != `FIR_MAX_TAPS) begin
                valid_cnt <= valid_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (wr.we) begin
            mem[wr_ptr] <= wr.data;
        end
    end

    //////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////

    // offset 0 is the newest sample
    assign rd_ptr   = wr_ptr - 1'b1 - offset;
    assign in_range = ({1'b0, offset} < valid_cnt);

    // older than the run reads as zero
    assign sample = in_range ? mem[rd_ptr] : '0;

endmodule

/* design/fir_settings.svh */
`ifndef FIR_SETTINGS_SVH
`define FIR_SETTINGS_SVH

// bus widths
`define FIR_ADDR_W      12
`define FIR_DATA_W      32

// coefficient and history depth
`define FIR_MAX_TAPS    32
`define FIR_IDX_W       5

// register map
`define FIR_REG_AP_CTRL 12'h000
`define FIR_REG_LENGTH  12'h010
`define FIR_REG_TAPS    12'h014

// coefficient k lives at base + 4k
`define FIR_TAP_BASE    12'h080

`endif

/* design/fir_top.sv */
`timescale 1ns/10ps

module fir_top
    import fir_pkg::*;
(
    input  logic       axis_clk,
    input  logic       axis_rst_n,

    // axi-lite slave
    input  logic       awvalid,
    output logic       awready,
    input  addr_t      awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  data_word_t wdata,
    input  logic       arvalid,
    output logic       arready,
    input  addr_t      araddr,
    output logic       rvalid,
    input  logic       rready,
    output data_word_t rdata,

    // axi-stream in and out
    input  logic       ss_tvalid,
    input  data_word_t ss_tdata,
    output logic       ss_tready,
    output logic       sm_tvalid,
    output data_word_t sm_tdata,
    output logic       sm_tlast,
    input  logic       sm_tready
);

    logic       start;
    logic       run_done;
    fir_cfg_t   cfg;
    idx_t       tap_idx;
    data_word_t tap_coef;
    sample_wr_t wr;
    idx_t       offset;
    data_word_t sample;

    fir_config_regs config_regs_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .wvalid     (wvalid),
        .arvalid    (arvalid),
        .rready     (rready),
        .awaddr     (awaddr),
        .araddr     (araddr),
        .wdata      (wdata),
        .awready    (awready),
        .wready     (wready),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .tap_idx    (tap_idx),
        .tap_coef   (tap_coef),
        .run_done   (run_done),
        .start      (start),
        .cfg        (cfg)
    );

    fir_sample_buffer sample_buffer_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .start      (start),
        .wr         (wr),
        .offset     (offset),
        .sample     (sample)
    );

    fir_mac_engine mac_engine_i (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .start      (start),
        .run_done   (run_done),
        .cfg        (cfg),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tready  (ss_tready),
        .sm_tready  (sm_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tlast   (sm_tlast),
        .sm_tdata   (sm_tdata),
        .wr         (wr),
        .offset     (offset),
        .tap_idx    (tap_idx),
        .sample     (sample),
        .tap_coef   (tap_coef)
    );

endmodule

/* list.f */
+incdir+design
design/fir_pkg.sv
design/fir_config_regs.sv
design/fir_sample_buffer.sv
design/fir_mac_engine.sv
design/fir_top.sv
verif/fir_properties.sv
verif/fir_tb.sv

/* verif/fir_properties.sv */
`timescale 1ns/10ps

module fir_properties
    import fir_pkg::*;
(
    input logic       axis_clk,
    input logic       axis_rst_n,
    input logic       awready,
    input logic       wready,
    input logic       rvalid,
    input logic       rready,
    input logic       ss_tready,
    input logic       sm_tvalid,
    input logic       sm_tready,
    input logic       sm_tlast,
    input data_word_t sm_tdata,
    input logic       done
);

    int err_cnt = 0;

    // output word frozen while the sink stalls
    sm_hold_a: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata) && $stable(sm_tlast))
    else begin
        err_cnt++;
        $error("sm stream changed before sm_tready");
    end

    rvalid_hold_a: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid)
    else begin
        err_cnt++;
        $error("rvalid dropped before rready");
    end

    // no intake between run end and the host acknowledging it
    no_intake_done_a: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        done |-> !ss_tready)
    else begin
        err_cnt++;
        $error("ss_tready high while done is set");
    end

    aw_w_pair_a: assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        awready == wready)
    else begin
        err_cnt++;
        $error("awready and wready differ");
    end

endmodule

bind fir_top fir_properties fir_properties_i (
    .axis_clk   (axis_clk),
    .axis_rst_n (axis_rst_n),
    .awready    (awready),
    .wready     (wready),
    .rvalid     (rvalid),
    .rready     (rready),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tready  (sm_tready),
    .sm_tlast   (sm_tlast),
    .sm_tdata   (sm_tdata),
    .done       (config_regs_i.ap_done)
);

/* verif/fir_tb.sv */
`timescale 1ns/10ps
`include "fir_settings.svh"

module fir_tb
    import fir_pkg::*;
();

    localparam int MAX_STALL = 4;
    localparam int RUNS      = 3;
    localparam int RUN_TAPS  [RUNS] = '{11, 32, 1};
    localparam int RUN_LEN   [RUNS] = '{24, 40, 8};
    localparam bit RUN_STALL [RUNS] = '{1'b1, 1'b0, 1'b0};

    // every sample may take its taps, the pipeline and the longest stall
    localparam int CYCLE_LIMIT = RUN_LEN[0] * (RUN_TAPS[0] + 3 + MAX_STALL)
                               + RUN_LEN[1] * (RUN_TAPS[1] + 3 + MAX_STALL)
                               + RUN_LEN[2] * (RUN_TAPS[2] + 3 + MAX_STALL)
                               + 2000;

    logic       axis_clk;
    logic       axis_rst_n;
    logic       awvalid;
    logic       awready;
    addr_t      awaddr;
    logic       wvalid;
    logic       wready;
    data_word_t wdata;
    logic       arvalid;
    logic       arready;
    addr_t      araddr;
    logic       rvalid;
    logic       rready;
    data_word_t rdata;
    logic       ss_tvalid;
    data_word_t ss_tdata;
    logic       ss_tready;
    logic       sm_tvalid;
    data_word_t sm_tdata;
    logic       sm_tlast;
    logic       sm_tready;

    data_word_t coef_m [`FIR_MAX_TAPS];
    data_word_t x_q [$];
    data_word_t lcg_state = 32'hfeb5_3b39;
    int         cyc = 0;

    fir_top fir_top_i (.*);

    initial begin
        axis_clk = 1'b0;
        forever #5 axis_clk = ~axis_clk;
    end

    //////////////////////////////////////////////////
    // reporting and compare tasks
    //////////////////////////////////////////////////

    task automatic report_failure(string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, data_word_t got, data_word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_ctrl(string name, ctrl_word_u got, ctrl_word_u exp);
        if (got.raw !== exp.raw) begin
            report_failure($sformatf("** Error: %s got 0x%h, expected 0x%h",
                                     name, got.raw, exp.raw));
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // watchdog, plus any assertion that fired
    always @(posedge axis_clk) begin
        cyc = cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            report_failure("timeout: the run did not finish within the cycle budget");
        end
        if (fir_top_i.fir_properties_i.err_cnt != 0) begin
            report_failure("a handshake assertion failed");
        end
    end

    //////////////////////////////////////////////////
    // stimulus and model
    //////////////////////////////////////////////////

    function automatic data_word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // y[n] over this run's samples only
    function automatic data_word_t model_output(int taps);
        data_word_t acc;
        int         n;
        n   = x_q.size() - 1;
        acc = '0;
        for (int k = 0; k < taps && k <= n; k++) begin
            acc = acc + coef_m[k] * x_q[n - k];
        end
        return acc;
    endfunction

    task automatic write_reg(addr_t addr, data_word_t data);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do begin
            @(posedge axis_clk);
            #1;
        end while (!awready);
        @(posedge axis_clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic read_reg(addr_t addr, output data_word_t data);
        araddr  = addr;
        arvalid = 1'b1;
        do begin
            @(posedge axis_clk);
            #1;
        end while (!arready);
        @(posedge axis_clk);
        #1;
        arvalid = 1'b0;
        while (!rvalid) begin
            @(posedge axis_clk);
            #1;
        end
        // rvalid waits one cycle for rready
        @(posedge axis_clk);
        #1;
        rready = 1'b1;
        data   = rdata;
        @(posedge axis_clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic expect_status(logic idle, logic done, logic start);
        data_word_t word;
        ctrl_word_u got;
        ctrl_word_u exp;
        read_reg(`FIR_REG_AP_CTRL, word);
        got.raw        = word;
        exp.raw        = '0;
        exp.ctrl.idle  = idle;
        exp.ctrl.done  = done;
        exp.ctrl.start = start;
        check_ctrl("ap_ctrl", got, exp);
    endtask

    task automatic run_filter(int taps, int len, bit stall);
        data_word_t word;
        data_word_t expect_y;
        ctrl_word_u go;
        int         hs_cyc;
        int         wait_n;
        x_q.delete();
        for (int k = 0; k < `FIR_MAX_TAPS; k++) begin
            coef_m[k] = lcg_next();
            write_reg(addr_t'(`FIR_TAP_BASE + 4 * k), coef_m[k]);
        end
        write_reg(`FIR_REG_TAPS, data_word_t'(taps));
        write_reg(`FIR_REG_LENGTH, data_word_t'(len));
        for (int k = 0; k < `FIR_MAX_TAPS; k++) begin
            read_reg(addr_t'(`FIR_TAP_BASE + 4 * k), word);
            check_word($sformatf("coef[%0d]", k), word, coef_m[k]);
        end
        read_reg(`FIR_REG_TAPS, word);
        check_word("tap_num", word, data_word_t'(taps));
        read_reg(`FIR_REG_LENGTH, word);
        check_word("data_len", word, data_word_t'(len));

        go.raw        = '0;
        go.ctrl.start = 1'b1;
        write_reg(`FIR_REG_AP_CTRL, go.raw);
        expect_status(1'b0, 1'b0, 1'b0);

        // busy, so these must not land
        for (int k = 0; k < 4; k++) begin
            write_reg(addr_t'(`FIR_TAP_BASE + 4 * k), ~coef_m[k]);
            read_reg(addr_t'(`FIR_TAP_BASE + 4 * k), word);
            check_word($sformatf("coef[%0d]", k), word, coef_m[k]);
        end

        sm_tready = !stall;
        for (int n = 0; n < len; n++) begin
            x_q.push_back(lcg_next());
            expect_y  = model_output(taps);
            ss_tdata  = x_q[n];
            ss_tvalid = 1'b1;
            while (!ss_tready) begin
                @(posedge axis_clk);
                #1;
            end
            @(posedge axis_clk);
            #1;
            ss_tvalid = 1'b0;
            hs_cyc    = cyc;
            while (!sm_tvalid) begin
                @(posedge axis_clk);
                #1;
            end
            if (cyc - hs_cyc != taps + 3) begin
                report_failure($sformatf("sm_tvalid came %0d cycles after the ss handshake, not %0d",
                                         cyc - hs_cyc, taps + 3));
            end
            check_word("sm_tdata", sm_tdata, expect_y);
            check_flag("sm_tlast", sm_tlast, n == len - 1);
            if (stall) begin
                wait_n = (lcg_next() >> 16) % (MAX_STALL + 1);
                repeat (wait_n) begin
                    @(posedge axis_clk);
                    #1;
                end
                sm_tready = 1'b1;
            end
            @(posedge axis_clk);
            #1;
            if (stall) begin
                sm_tready = 1'b0;
            end
        end

        // first read sees done, second sees idle again
        expect_status(1'b0, 1'b1, 1'b0);
        expect_status(1'b1, 1'b0, 1'b0);
        check_flag("ss_tready", ss_tready, 1'b0);
        check_flag("sm_tvalid", sm_tvalid, 1'b0);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        sm_tready  = 1'b0;
        repeat (4) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;

        expect_status(1'b1, 1'b0, 1'b0);
        check_flag("ss_tready", ss_tready, 1'b0);
        check_flag("sm_tvalid", sm_tvalid, 1'b0);

        for (int r = 0; r < RUNS; r++) begin
            run_filter(RUN_TAPS[r], RUN_LEN[r], RUN_STALL[r]);
        end

        if (fir_top_i.fir_properties_i.err_cnt == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            report_failure("a handshake assertion failed");
        end
    end

endmodule
